/* compile.f */
hw/uartPkg.sv
hw/uartBitTimer.sv
hw/uartTx.sv
hw/uartRx.sv
hw/uartRegs.sv
hw/uartTop.sv
verif/uartTb_assert.sv
verif/uartTb.sv

/* Bender.yml */
package:
  name: uart

sources:
  - hw/uartPkg.sv
  - hw/uartBitTimer.sv
  - hw/uartTx.sv
  - hw/uartRx.sv
  - hw/uartRegs.sv
  - hw/uartTop.sv
  - target: simulation
    files:
      - verif/uartTb_assert.sv
      - verif/uartTb.sv

/* verif/uartTb.sv */
// ########################################
// uart testbench
// directed tests over the bus and the
// serial lines of the uart top level
// ########################################
`timescale 1ns/1ps

module uartTb;
	import uartPkg::*;

	localparam int clkPeriod  = 40;
	localparam int maxDiv     = 16; // largest divisor the tests program
	localparam int numFrames  = 15; // frames sent or watched over all tests
	localparam int watchdogNs = 2 * numFrames * frameBits * maxDiv * clkPeriod;

	logic                clk;
	logic                rstN;
	busReq_t             req;
	uartWord_u           rdata;
	logic                tx;
	logic                rxDrv;    // serial stimulus
	logic                loopback; // tx fed back into rx
	logic                rxLine;
	logic [31:0]         lfsr;
	logic [divWidth-1:0] curDiv;   // divisor the dut should hold
	string               curTest;
	int                  testCount;
	int                  checkCount;
	int                  errCount;
	int                  testErrStart;

	assign rxLine = loopback ? tx : rxDrv;

	uartTop dut_i (
		.clk   (clk),
		.rstN  (rstN),
		.req   (req),
		.rdata (rdata),
		.tx    (tx),
		.rx    (rxLine)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawByte(output logic [byteWidth-1:0] value);
		int i;
		value = '0;
		for (i = 0; i < byteWidth; i++) begin
			lfsr  = lfsrStep(lfsr); // one step per bit
			value = {value[byteWidth-2:0], lfsr[0]};
		end
	endtask

	task automatic busWrite(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] value);
		busReq_t r;
		r       = '0;
		r.wr    = 1'b1;
		r.addr  = addr;
		r.wdata = value;
		@(posedge clk);
		req <= r;
		@(posedge clk); // dut captures here
		req <= '0;
	endtask

	task automatic busRead(input logic [addrWidth-1:0] addr, output uartWord_u value);
		busReq_t r;
		r      = '0;
		r.rd   = 1'b1;
		r.addr = addr;
		@(posedge clk);
		req <= r;
		@(negedge clk);
		value = rdata; // combinational read, flags clear at the next edge
		@(posedge clk);
		req <= '0;
	endtask

	// start bit, data lsb first, then the given stop level
	task automatic sendSerial(input logic [byteWidth-1:0] value, input logic stopBit,
		input int bitCycles);
		logic [frameBits-1:0] frame;
		int                   i;
		frame = {stopBit, value, 1'b0};
		for (i = 0; i < frameBits; i++) begin
			@(posedge clk);
			rxDrv <= frame[i];
			repeat (bitCycles - 1) @(posedge clk);
		end
		@(posedge clk);
		rxDrv <= 1'b1; // back to idle
	endtask

	task automatic captureSerial(input int bitCycles, output logic [frameBits-1:0] frame);
		int i;
		@(negedge tx); // start bit edge
		repeat (bitCycles / 2) @(posedge clk);
		@(negedge clk);
		frame[0] = tx;
		for (i = 1; i < frameBits; i++) begin
			repeat (bitCycles) @(negedge clk);
			frame[i] = tx;
		end
	endtask

	// idle req has address addrTx, so rdata shows status without a read strobe
	task automatic waitStatus(input logic [2:0] want);
		int n;
		for (n = 0; n < 4 * frameBits * curDiv; n++) begin
			@(negedge clk);
			if ({rdata.status.busy, rdata.status.rxValid, rdata.status.overrun} == want) return;
		end
		noteFailure($sformatf("status flags {busy,rxValid,overrun} never reached %b", want));
	endtask

	task automatic checkWord(input string what, input uartWord_u exp, input uartWord_u act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("[ERROR] %s %s: expected %h, got %h", curTest, what, exp, act);
		end
	endtask

	task automatic checkByte(input string what, input logic [byteWidth-1:0] exp,
		input logic [byteWidth-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("[ERROR] %s %s: expected %h, got %h", curTest, what, exp, act);
		end
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("[ERROR] %s %s: expected %b, got %b", curTest, what, exp, act);
		end
	endtask

	task automatic noteFailure(input string msg);
		errCount++;
		$display("%s failed: %s", curTest, msg);
	endtask

	task automatic beginTest(input string name);
		curTest      = name;
		testErrStart = errCount;
		testCount++;
	endtask

	task automatic endTest();
		if (errCount == testErrStart) $display("test %s passed", curTest);
		else $display("test %s failed with %0d errors", curTest, errCount - testErrStart);
	endtask

	task automatic testReset();
		uartWord_u word;
		beginTest("resetState");
		busRead(addrTx, word);
		checkWord("status", '0, word);
		busRead(addrDiv, word);
		checkWord("divisor", uartWord_u'(defaultDiv), word);
		checkBit("tx idle", 1'b1, tx);
		endTest();
	endtask

	task automatic testTxFrame();
		logic [byteWidth-1:0] value;
		logic [frameBits-1:0] frame;
		int                   k;
		int                   lastBusy;
		beginTest("txFrame");
		busWrite(addrDiv, 16'd8);
		curDiv   = 16'd8;
		lastBusy = frameBits * curDiv; // busy falls one edge later
		drawByte(value);
		busWrite(addrTx, dataWidth'(value));
		fork
			captureSerial(curDiv, frame);
			for (k = 0; k <= lastBusy + 1; k++) begin
				@(negedge clk);
				if (k == 0 || k == lastBusy) checkBit("busy", 1'b1, rdata.status.busy);
				if (k == lastBusy + 1) checkBit("busy end", 1'b0, rdata.status.busy);
			end
		join
		checkBit("start bit", 1'b0, frame[0]);
		checkByte("data bits", value, frame[byteWidth:1]);
		checkBit("stop bit", 1'b1, frame[frameBits-1]);
		endTest();
	endtask

	task automatic testTxDropped();
		logic [byteWidth-1:0] first;
		logic [frameBits-1:0] frame;
		logic                 lowSeen;
		beginTest("txDropped");
		drawByte(first);
		busWrite(addrTx, dataWidth'(first));
		fork
			captureSerial(curDiv, frame);
			begin
				repeat (2 * curDiv) @(posedge clk); // mid frame
				busWrite(addrTx, dataWidth'(~first));
			end
		join
		checkByte("first frame", first, frame[byteWidth:1]);
		checkBit("stop bit", 1'b1, frame[frameBits-1]);
		lowSeen = 1'b0;
		repeat (2 * frameBits * curDiv) begin
			@(negedge clk);
			if (!tx) lowSeen = 1'b1;
		end
		checkBit("second frame", 1'b0, lowSeen);
		endTest();
	endtask

	task automatic testRxClear();
		logic [byteWidth-1:0] value;
		uartWord_u            word;
		beginTest("rxClear");
		drawByte(value);
		sendSerial(value, 1'b1, curDiv);
		waitStatus(3'b010);
		busRead(addrRx, word);
		checkByte("rx byte", value, word.data.value);
		busRead(addrTx, word);
		checkBit("rxValid cleared", 1'b0, word.status.rxValid);
		endTest();
	endtask

	task automatic testOverrun();
		logic [byteWidth-1:0] first;
		logic [byteWidth-1:0] second;
		uartWord_u            word;
		uartWord_u            exp;
		beginTest("overrunFraming");
		drawByte(first);
		drawByte(second);
		sendSerial(first, 1'b1, curDiv);
		sendSerial(second, 1'b1, curDiv); // no read in between
		waitStatus(3'b011);
		exp                = '0;
		exp.status.rxValid = 1'b1;
		exp.status.overrun = 1'b1;
		busRead(addrTx, word);
		checkWord("status", exp, word);
		busRead(addrRx, word);
		checkByte("held byte", second, word.data.value);
		busRead(addrTx, word);
		checkWord("flags cleared", '0, word);
		sendSerial(first, 1'b0, curDiv); // low stop bit
		// mid stop bit plus synchroniser lag lands past the end of the frame
		repeat (curDiv) @(negedge clk);
		checkBit("rxValid after bad stop", 1'b0, rdata.status.rxValid);
		sendSerial(second, 1'b1, curDiv);
		waitStatus(3'b010);
		busRead(addrRx, word);
		checkByte("after framing drop", second, word.data.value);
		endTest();
	endtask

	task automatic testLoopback();
		logic [byteWidth-1:0] value;
		logic [divWidth-1:0]  newDiv;
		uartWord_u            word;
		int                   d;
		int                   n;
		beginTest("divLoopback");
		busWrite(addrDiv, dataWidth'(minDiv - 1'b1)); // below the limit
		busRead(addrDiv, word);
		checkWord("divisor kept", uartWord_u'(curDiv), word);
		@(posedge clk);
		loopback <= 1'b1;
		for (d = 0; d < 2; d++) begin
			newDiv = (d == 0) ? 16'd12 : 16'd16;
			busWrite(addrDiv, newDiv);
			curDiv = newDiv;
			busRead(addrDiv, word);
			checkWord("divisor", uartWord_u'(curDiv), word);
			for (n = 0; n < 3; n++) begin
				drawByte(value);
				busWrite(addrTx, dataWidth'(value));
				waitStatus(3'b010); // frame done and byte back
				busRead(addrRx, word);
				checkByte("loopback byte", value, word.data.value);
			end
		end
		@(posedge clk);
		loopback <= 1'b0;
		endTest();
	endtask

	initial begin
		#(watchdogNs);
		$display("watchdog: run still going after %0d ns, stopping", watchdogNs);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		rstN       = 1'b0;
		req        = '0;
		rxDrv      = 1'b1; // idle line
		loopback   = 1'b0;
		lfsr       = 32'h9e20_8e3c;
		curDiv     = defaultDiv;
		testCount  = 0;
		checkCount = 0;
		errCount   = 0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		testReset();
		testTxFrame();
		testTxDropped();
		testRxClear();
		testOverrun();
		testLoopback();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verif/uartTb_assert.sv */
// ########################################
// uart assertions
// idle line level and flag rules checked
// inside the uart top level
// ########################################
`timescale 1ns/1ps

module uartTb_assert (
	input logic clk,
	input logic rstN,
	input logic tx,
	input logic txBusy,
	input logic txStart,
	input logic rxDone,
	input logic rxValid
);
	logic doneSeen; // a good frame arrived since reset

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			doneSeen <= 1'b0;
		end else if (rxDone) begin
			doneSeen <= 1'b1;
		end
	end

	// idle line is a mark
	idleHigh: assert property (@(posedge clk) disable iff (!rstN) !txBusy |-> tx)
		else $error("tx low while the transmitter is idle");

	noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN) !(txStart && txBusy))
		else $error("txStart pulsed during a frame");

	// no byte can be valid before one was received
	validNeedsDone: assert property (@(posedge clk) disable iff (!rstN) !doneSeen |-> !rxValid)
		else $error("rxValid set before any rxDone");

endmodule

bind uartTop uartTb_assert assert_i (
	.clk     (clk),
	.rstN    (rstN),
	.tx      (tx),
	.txBusy  (txBusy),
	.txStart (txStart),
	.rxDone  (rxDone),
	.rxValid (regs_i.rxValid)
);

/* hw/uartTop.sv */
// ########################################
// uart top
// memory-mapped 8N1 uart for a 16-bit bus
// ########################################
`timescale 1ns/1ps

module uartTop (
	input  logic               clk,
	input  logic               rstN,
	input  uartPkg::busReq_t   req,
	output uartPkg::uartWord_u rdata,
	output logic               tx,
	input  logic               rx
);
	import uartPkg::*;

	logic                 txStart;
	logic                 txBusy;
	logic [byteWidth-1:0] txByte;
	logic [divWidth-1:0]  div;     // shared by both directions
	logic                 rxDone;
	logic [byteWidth-1:0] rxByte;

	uartRegs regs_i (
		.clk     (clk),
		.rstN    (rstN),
		.req     (req),
		.rdata   (rdata),
		.txBusy  (txBusy),
		.txStart (txStart),
		.txByte  (txByte),
		.div     (div),
		.rxDone  (rxDone),
		.rxByte  (rxByte)
	);

	uartTx tx_i (
		.clk   (clk),
		.rstN  (rstN),
		.start (txStart),
		.data  (txByte),
		.div   (div),
		.busy  (txBusy),
		.tx    (tx)
	);

	uartRx rx_i (
		.clk  (clk),
		.rstN (rstN),
		.rx   (rx),
		.div  (div),
		.done (rxDone),
		.data (rxByte)
	);

endmodule

/* hw/uartRegs.sv */
// ########################################
// uart register block
// bus decode, divisor, received byte,
// status flags and the read word
// ########################################
`timescale 1ns/1ps

module uartRegs (
	input  logic                          clk,
	input  logic                          rstN,
	input  uartPkg::busReq_t              req,
	output uartPkg::uartWord_u            rdata,
	input  logic                          txBusy,
	output logic                          txStart, // one-cycle frame request
	output logic [uartPkg::byteWidth-1:0] txByte,
	output logic [uartPkg::divWidth-1:0]  div,
	input  logic                          rxDone,
	input  logic [uartPkg::byteWidth-1:0] rxByte
);
	import uartPkg::*;

	logic                 wrTx;
	logic                 wrDiv;
	logic                 rdTx;
	logic                 rdRx;
	logic                 txAccept;
	logic                 rxValid;
	logic                 overrun;
	logic [byteWidth-1:0] rxHeld; // last good byte from the receiver

	assign wrTx  = req.wr && (req.addr == addrTx);
	assign wrDiv = req.wr && (req.addr == addrDiv);
	assign rdTx  = req.rd && (req.addr == addrTx);
	assign rdRx  = req.rd && (req.addr == addrRx);

	// a request already in flight also counts as busy
	assign txAccept = wrTx && !txBusy && !txStart;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			txStart <= 1'b0;
			div     <= defaultDiv;
			rxValid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			txStart <= txAccept;
			if (wrDiv && (req.wdata[divWidth-1:0] >= minDiv)) begin
				div <= req.wdata[divWidth-1:0];
			end
			if (rdTx) overrun <= 1'b0; // status read acknowledges overrun
			if (rxDone && rxValid && !rdRx) overrun <= 1'b1; // old byte never read
			if (rxDone) begin
				rxValid <= 1'b1;
			end else if (rdRx) begin
				rxValid <= 1'b0;
			end
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (txAccept) txByte <= req.wdata[byteWidth-1:0];
		if (rxDone) rxHeld <= rxByte; // newer byte wins on overrun
	end

	// read word through the view picked by the address
	always_comb begin
		rdata = '0;
		unique case (req.addr)
			addrTx: begin
				rdata.status.busy    = txBusy || txStart;
				rdata.status.rxValid = rxValid;
				rdata.status.overrun = overrun;
			end
			addrRx:  rdata.data.value = rxHeld;
			addrDiv: rdata = uartWord_u'(div); // zero-extended divisor
			default: rdata = '0;
		endcase
	end

endmodule

/* hw/uartRx.sv */
// ########################################
// uart receiver
// finds the start edge, samples each bit
// in its middle and assembles the byte
// ########################################
`timescale 1ns/1ps

module uartRx (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          rx,   // async serial input
	input  logic [uartPkg::divWidth-1:0]  div,
	output logic                          done, // one cycle per good frame
	output logic [uartPkg::byteWidth-1:0] data
);
	import uartPkg::*;

	typedef enum logic [1:0] {
		sIdle,
		sStart,
		sData,
		sStop
	} rxState_t;

	typedef logic [$clog2(byteWidth)-1:0] bitIdx_t;

	rxState_t             state;
	bitIdx_t              bitIdx;
	logic                 rxMeta;
	logic                 rxSync;
	logic                 rxPrev;
	logic                 fall;
	logic                 midTick;
	logic [byteWidth-1:0] shiftReg;

	// two-flop synchroniser plus one flop for edge detection
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign fall = rxPrev && !rxSync;

	uartBitTimer timer_i (
		.clk     (clk),
		.rstN    (rstN),
		.enable  (state != sIdle),
		.restart ((state == sIdle) && fall), // start edge sets bit phase
		.div     (div),
		.tick    (),
		.midTick (midTick)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state  <= sIdle;
			bitIdx <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			unique case (state)
				sIdle: begin
					if (fall) state <= sStart;
				end
				sStart: begin
					if (midTick) begin
						// still low in mid bit means a real start
						state  <= rxSync ? sIdle : sData;
						bitIdx <= '0;
					end
				end
				sData: begin
					if (midTick) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == bitIdx_t'(byteWidth - 1)) state <= sStop;
					end
				end
				sStop: begin
					if (midTick) begin
						done  <= rxSync; // low stop bit is a framing drop
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// lsb arrives first so bits enter from the top
	always_ff @(posedge clk) begin
		if ((state == sData) && midTick) begin
			shiftReg <= {rxSync, shiftReg[byteWidth-1:1]};
		end
	end

	assign data = shiftReg; // stable while idle, so valid with done

endmodule

/* hw/uartTx.sv */
// ########################################
// uart transmitter
// shifts one byte out as an 8N1 frame
// ########################################
`timescale 1ns/1ps

module uartTx (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          start, // one-cycle load request
	input  logic [uartPkg::byteWidth-1:0] data,
	input  logic [uartPkg::divWidth-1:0]  div,
	output logic                          busy,
	output logic                          tx     // serial line
);
	import uartPkg::*;

	typedef logic [$clog2(frameBits)-1:0] bitIdx_t;

	logic [byteWidth:0] shiftReg; // byte plus start bit in the lsb
	bitIdx_t            bitIdx;   // bit currently on the line
	logic               load;
	logic               tick;
	logic               lastBit;

	assign load    = start && !busy; // a start during a frame is ignored
	assign lastBit = (bitIdx == bitIdx_t'(frameBits - 1));

	uartBitTimer timer_i (
		.clk     (clk),
		.rstN    (rstN),
		.enable  (busy),
		.restart (load),
		.div     (div),
		.tick    (tick),
		.midTick ()
	);

	// busy and bit position
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy   <= 1'b0;
			bitIdx <= '0;
		end else if (load) begin
			busy   <= 1'b1;
			bitIdx <= '0;
		end else if (tick) begin
			if (lastBit) begin
				busy   <= 1'b0; // stop bit has run its full period
				bitIdx <= '0;
			end else begin
				bitIdx <= bitIdx + 1'b1;
			end
		end
	end

	// shift right, ones come in from the top and form the stop bit
	always_ff @(posedge clk) begin
		if (load) begin
			shiftReg <= {data, 1'b0};
		end else if (tick) begin
			shiftReg <= {1'b1, shiftReg[byteWidth:1]};
		end
	end

	assign tx = busy ? shiftReg[0] : 1'b1; // idle line stays high

endmodule

/* hw/uartBitTimer.sv */
// ########################################
// uart bit timer
// counts one bit period and flags its end
// and its middle
// ########################################
`timescale 1ns/1ps

module uartBitTimer (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         enable,  // count while high
	input  logic                         restart, // realign to a new frame
	input  logic [uartPkg::divWidth-1:0] div,
	output logic                         tick,    // last cycle of a bit
	output logic                         midTick  // middle of a bit
);
	import uartPkg::*;

	logic [divWidth-1:0] cnt;
	logic [divWidth-1:0] curDiv; // period of the bit in progress
	logic                lastCycle;

	assign lastCycle = (cnt == curDiv - 1'b1);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cnt    <= '0;
			curDiv <= defaultDiv;
		end else if (restart) begin
			cnt    <= '0;
			curDiv <= div; // new frame picks up the current divisor
		end else if (enable) begin
			if (lastCycle) begin
				cnt    <= '0;
				curDiv <= div; // divisor changes land on a bit boundary
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign tick    = enable && lastCycle;
	assign midTick = enable && (cnt == (curDiv >> 1)); // half of div

endmodule

/* hw/uartPkg.sv */
// ########################################
// uart package
// address map, widths, bus request and the
// status/data word seen by the cpu
// ########################################
package uartPkg;

	localparam int dataWidth = 16; // cpu bus word
	localparam int byteWidth = 8;
	localparam int frameBits = 10; // start + 8 data + stop
	localparam int divWidth  = 16;
	localparam int addrWidth = 2;

	// 115200 baud at 25 MHz
	localparam logic [divWidth-1:0] defaultDiv = 16'd217;
	localparam logic [divWidth-1:0] minDiv     = 16'd4; // smaller writes are ignored

	localparam logic [addrWidth-1:0] addrTx  = 2'd0; // wr sends, rd gives status
	localparam logic [addrWidth-1:0] addrRx  = 2'd1; // rd gives byte and clears rxValid
	localparam logic [addrWidth-1:0] addrDiv = 2'd2; // baud divisor

	typedef struct packed {
		logic                 wr;    // one-cycle write strobe
		logic                 rd;    // one-cycle read strobe
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	} busReq_t;

	// flags sit at the top of the word
	typedef struct packed {
		logic                 busy;
		logic                 rxValid;
		logic                 overrun;
		logic [dataWidth-4:0] pad;
	} statusView_t;

	typedef struct packed {
		logic [dataWidth-byteWidth-1:0] pad;
		logic [byteWidth-1:0]           value; // received character
	} dataView_t;

	// same word, meaning picked by the address
	typedef union packed {
		statusView_t status;
		dataView_t   data;
	} uartWord_u;

endpackage
